// ==== copad.f ====
+incdir+.
copad_pkg.sv
cluster_input_stage.sv
pad_window.sv
copad_match_array.sv
match_output_stage.sv
copad.sv
tb_clock_gen.sv
copad_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := copad_tb
RTL_TOP    := copad
FILELIST   := copad.f
FLAGS      := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation finished: FAIL
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== copad_tb.sv ====
// directed and random stimulus, reference model and output checks for the co-pad finder
`default_nettype none

`include "copad_config.svh"

module copad_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import copad_pkg::*;

    localparam int RESET_CYCLES = 2;
    localparam int LATENCY      = 2;    // input stage + output stage
    localparam int TOP_ROLL     = (1 << `COPAD_ROLL_BITS) - 1;
    localparam int NUM_RANDOM   = 200;

    typedef struct packed {
        match_vec_t  match;
        match_vec_t  upper;
        match_vec_t  lower;
        logic        any;
        int unsigned due;    // clock edge after which the result is visible
    } expected_t;

    logic              clock;
    logic              rst_n;
    chamber_clusters_t gem_a;
    chamber_clusters_t gem_b;
    match_cfg_t        cfg;
    match_vec_t        match;
    match_vec_t        match_upper;
    match_vec_t        match_lower;
    logic              any_match;

    expected_t   exp_q[$];
    int unsigned edge_count    = 0;
    int unsigned pushed        = 0;
    int unsigned checked       = 0;
    int unsigned reset_checked = 0;
    logic [31:0] rng_state     = 32'h9f2c;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_inst (
        .clock (clock),
        .rst_n (rst_n)
    );

    copad copad_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .gem_a       (gem_a),
        .gem_b       (gem_b),
        .cfg         (cfg),
        .match       (match),
        .match_upper (match_upper),
        .match_lower (match_lower),
        .any_match   (any_match)
    );

    always @(posedge clock) edge_count <= edge_count + 1;

    // -------------------------------------------------------------------
    // reference model and helpers
    // -------------------------------------------------------------------

    function automatic expected_t copad_ref(input chamber_clusters_t a,
                                            input chamber_clusters_t b,
                                            input match_cfg_t c);
        expected_t  r;
        match_vec_t same;
        int         delta;
        int         lo;
        int         hi;
        int         first;
        int         last;
        int         ar;
        int         br;
        logic       overlap;
        r     = '0;
        same  = '0;
        delta = c.neighbor_pad ? int'(c.delta_pad) : 0;
        for (int i = 0; i < `COPAD_NUM_CLUSTERS; i++) begin
            ar = int'(a[i].roll);
            lo = int'(a[i].pad) - delta;
            if (lo < 0) lo = 0;
            hi = int'(a[i].pad) + int'(a[i].cnt) + delta;
            if (hi > `COPAD_MAX_PAD) hi = `COPAD_MAX_PAD;
            for (int j = 0; j < `COPAD_NUM_CLUSTERS; j++) begin
                br      = int'(b[j].roll);
                first   = int'(b[j].pad);
                last    = first + int'(b[j].cnt);
                overlap = ((first >= lo) && (first <= hi)) || ((last >= lo) && (last <= hi));
                if (a[i].valid && b[j].valid && overlap) begin
                    if (ar == br) same[i] = 1'b1;
                    if ((ar != 0) && (ar == br + 1)) r.upper[i] = 1'b1;
                    if ((ar != TOP_ROLL) && (ar + 1 == br)) r.lower[i] = 1'b1;
                end
            end
        end
        r.match = same | (c.neighbor_roll ? (r.upper | r.lower) : '0);
        r.any   = |r.match;
        return r;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic cluster_t make_cluster(input logic [`COPAD_ROLL_BITS-1:0] roll,
                                              input pad_t pad,
                                              input logic [`COPAD_CNT_BITS-1:0] cnt);
        cluster_t c;
        c.valid = 1'b1;
        c.roll  = roll;
        c.pad   = pad;
        c.cnt   = cnt;
        return c;
    endfunction

    function automatic match_cfg_t make_cfg(input logic nr, input logic np,
                                            input logic [`COPAD_DELTA_BITS-1:0] delta);
        match_cfg_t c;
        c.neighbor_roll = nr;
        c.neighbor_pad  = np;
        c.delta_pad     = delta;
        return c;
    endfunction

    // -------------------------------------------------------------------
    // failure reporting and compare tasks
    // -------------------------------------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_match_vec(input string name, input match_vec_t actual,
                                   input match_vec_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error: time %0t, %s = %b, expected %b",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_any_match(input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error: time %0t, any_match = %b, expected %b",
                                     $time, actual, expected));
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock) begin : compare_outputs
        expected_t e;
        if (rst_n && (edge_count < RESET_CYCLES + LATENCY)) begin
            check_match_vec("match", match, '0);    // nothing left over from reset
            check_match_vec("match_upper", match_upper, '0);
            check_match_vec("match_lower", match_lower, '0);
            check_any_match(any_match, 1'b0);
            reset_checked++;
        end else if (exp_q.size() > 0) begin
            if (exp_q[0].due == edge_count) begin
                e = exp_q.pop_front();
                check_match_vec("match", match, e.match);
                check_match_vec("match_upper", match_upper, e.upper);
                check_match_vec("match_lower", match_lower, e.lower);
                check_any_match(any_match, e.any);
                checked++;
            end else if (exp_q[0].due < edge_count) begin
                report_failure("an expected result was never compared");
            end
        end
    end

    // -------------------------------------------------------------------
    // stimulus
    // -------------------------------------------------------------------

    task automatic push_expected(input chamber_clusters_t a, input chamber_clusters_t b,
                                 input match_cfg_t c);
        expected_t e;
        e     = copad_ref(a, b, c);
        e.due = edge_count + LATENCY;
        exp_q.push_back(e);
        pushed++;
    endtask

    task automatic drive_crossing(input chamber_clusters_t a, input chamber_clusters_t b,
                                  input match_cfg_t c);
        @(posedge clock);
        #1;
        gem_a = a;
        gem_b = b;
        cfg   = c;
        push_expected(a, b, c);
    endtask

    // one A and one B cluster with every other slot empty
    task automatic drive_pair(input int a_slot, input cluster_t ac, input int b_slot,
                              input cluster_t bc, input match_cfg_t c);
        chamber_clusters_t a;
        chamber_clusters_t b;
        a         = '0;
        b         = '0;
        a[a_slot] = ac;
        b[b_slot] = bc;
        drive_crossing(a, b, c);
    endtask

    task automatic exact_match_sequence();
        match_cfg_t c;
        cluster_t   ac;
        cluster_t   ghost;
        c     = make_cfg(1'b0, 1'b0, 4'd5);    // delta must be ignored
        ac    = make_cluster(3'd3, 8'd20, 3'd2);    // pads 20..22
        ghost = make_cluster(3'd3, 8'd20, 3'd0);
        ghost.valid = 1'b0;
        drive_pair(0, ac, 5, make_cluster(3'd3, 8'd22, 3'd4), c);
        drive_pair(0, ac, 5, make_cluster(3'd3, 8'd23, 3'd0), c);
        drive_pair(0, ac, 5, make_cluster(3'd3, 8'd16, 3'd4), c);
        drive_pair(0, ac, 5, make_cluster(3'd3, 8'd16, 3'd3), c);
        drive_pair(7, ac, 2, make_cluster(3'd3, 8'd18, 3'd7), c);    // spans with no end inside
        drive_pair(7, ac, 0, make_cluster(3'd2, 8'd20, 3'd0), c);
        drive_pair(0, ac, 5, ghost, c);
    endtask

    task automatic pad_window_sequence();
        match_cfg_t c;
        c = make_cfg(1'b0, 1'b1, 4'd5);
        drive_pair(1, make_cluster(3'd1, 8'd2, 3'd0), 3, make_cluster(3'd1, 8'd0, 3'd0), c);
        drive_pair(1, make_cluster(3'd1, 8'd2, 3'd0), 3, make_cluster(3'd1, 8'd8, 3'd0), c);
        drive_pair(2, make_cluster(3'd1, 8'd50, 3'd1), 4, make_cluster(3'd1, 8'd56, 3'd0), c);
        drive_pair(2, make_cluster(3'd1, 8'd50, 3'd1), 4, make_cluster(3'd1, 8'd57, 3'd0), c);
        drive_pair(2, make_cluster(3'd1, 8'd50, 3'd1), 4, make_cluster(3'd1, 8'd40, 3'd5), c);
        drive_pair(2, make_cluster(3'd1, 8'd50, 3'd1), 4, make_cluster(3'd1, 8'd39, 3'd5), c);
        // window clamped at the last pad near the top of the roll
        drive_pair(6, make_cluster(3'd1, 8'd189, 3'd7), 6, make_cluster(3'd1, 8'd191, 3'd0), c);
        drive_pair(6, make_cluster(3'd1, 8'd189, 3'd7), 6, make_cluster(3'd1, 8'd183, 3'd0), c);
        drive_pair(6, make_cluster(3'd1, 8'd189, 3'd7), 6, make_cluster(3'd1, 8'd184, 3'd0), c);
        // B starts below the window and ends at pad 192, only the clamp keeps it out
        drive_pair(6, make_cluster(3'd1, 8'd191, 3'd2), 6, make_cluster(3'd1, 8'd185, 3'd7), c);
        c = make_cfg(1'b0, 1'b1, 4'd15);
        drive_pair(3, make_cluster(3'd6, 8'd3, 3'd0), 7, make_cluster(3'd6, 8'd0, 3'd0), c);
        drive_pair(3, make_cluster(3'd6, 8'd180, 3'd3), 7, make_cluster(3'd6, 8'd191, 3'd0), c);
        c = make_cfg(1'b0, 1'b0, 4'd5);
        drive_pair(2, make_cluster(3'd1, 8'd50, 3'd1), 4, make_cluster(3'd1, 8'd53, 3'd0), c);
    endtask

    task automatic neighbor_roll_sequence();
        logic [`COPAD_ROLL_BITS-1:0] a_roll [8] = '{3'd4, 3'd4, 3'd0, 3'd7, 3'd0, 3'd7, 3'd2, 3'd5};
        logic [`COPAD_ROLL_BITS-1:0] b_roll [8] = '{3'd3, 3'd5, 3'd7, 3'd0, 3'd1, 3'd6, 3'd4, 3'd5};
        for (int nr = 0; nr < 2; nr++) begin
            for (int k = 0; k < 8; k++) begin
                drive_pair(k, make_cluster(a_roll[k], 8'd100, 3'd0),
                           7 - k, make_cluster(b_roll[k], 8'd100, 3'd0),
                           make_cfg(nr[0], 1'b0, 4'd0));
            end
        end
    endtask

    function automatic cluster_t random_cluster(input logic [31:0] r);
        cluster_t c;
        c.valid = (r[1:0] != 2'b00);
        c.roll  = r[4:2];
        c.pad   = r[12:5] % 8'd192;    // keep pads on the roll
        c.cnt   = r[15:13];
        return c;
    endfunction

    task automatic random_traffic_sequence();
        chamber_clusters_t a;
        chamber_clusters_t b;
        logic [31:0]       r;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            for (int i = 0; i < `COPAD_NUM_CLUSTERS; i++) begin
                a[i] = random_cluster(next_random());
                b[i] = random_cluster(next_random());
            end
            r = next_random();
            drive_crossing(a, b, make_cfg(r[16], r[17], r[21:18]));
        end
    endtask

    // -------------------------------------------------------------------
    // main sequence
    // -------------------------------------------------------------------

    initial begin : main_sequence
        chamber_clusters_t a;
        chamber_clusters_t b;
        int                waited;
        // every pair matches, so only reset can keep the outputs low
        for (int i = 0; i < `COPAD_NUM_CLUSTERS; i++) begin
            a[i] = make_cluster(3'(i), 8'(10 * i), 3'd1);
            b[i] = make_cluster(3'(i), 8'(10 * i), 3'd1);
        end
        gem_a = a;
        gem_b = b;
        cfg   = make_cfg(1'b1, 1'b1, 4'd2);

        waited = 0;
        while (!rst_n) begin
            @(negedge clock);
            waited++;
            if (waited > 4 * RESET_CYCLES) report_failure("reset was never released");
        end
        push_expected(a, b, cfg);    // held crossing is sampled at the first edge out of reset

        exact_match_sequence();
        pad_window_sequence();
        neighbor_roll_sequence();
        random_traffic_sequence();

        waited = 0;
        while (exp_q.size() > 0) begin
            @(posedge clock);
            waited++;
            if (waited > 4 * LATENCY) report_failure("results still pending after the last crossing");
        end

        if ((checked == pushed) && (reset_checked == LATENCY)) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure("fewer results were compared than crossings were driven");
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// tb_clock_gen: testbench clock and power-on reset
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,    // ns, 100 ns period
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== copad.sv ====
// copad: co-pad finder top level, input stage, match array and output stage
`default_nettype none

module copad (
    input  wire logic                          clock,
    input  wire logic                          rst_n,
    input  wire copad_pkg::chamber_clusters_t  gem_a,
    input  wire copad_pkg::chamber_clusters_t  gem_b,
    input  wire copad_pkg::match_cfg_t         cfg,
    output copad_pkg::match_vec_t              match,
    output copad_pkg::match_vec_t              match_upper,
    output copad_pkg::match_vec_t              match_lower,
    output logic                               any_match
);

    import copad_pkg::*;

    chamber_clusters_t gem_a_q;       // registered crossing
    chamber_clusters_t gem_b_q;
    match_cfg_t        cfg_q;
    roll_match_t       roll_match;    // combinational pair result

    cluster_input_stage cluster_input_stage_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .gem_a   (gem_a),
        .gem_b   (gem_b),
        .cfg     (cfg),
        .gem_a_q (gem_a_q),
        .gem_b_q (gem_b_q),
        .cfg_q   (cfg_q)
    );

    copad_match_array copad_match_array_inst (
        .gem_a      (gem_a_q),
        .gem_b      (gem_b_q),
        .cfg        (cfg_q),
        .roll_match (roll_match)
    );

    match_output_stage match_output_stage_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .roll_match    (roll_match),
        .neighbor_roll (cfg_q.neighbor_roll),    // same crossing as roll_match
        .match         (match),
        .match_upper   (match_upper),
        .match_lower   (match_lower),
        .any_match     (any_match)
    );

endmodule

`default_nettype wire

// ==== match_output_stage.sv ====
// neighbour-roll combine and output registers for the match vectors
`default_nettype none

`include "copad_config.svh"

module match_output_stage (
    input  wire logic                    clock,
    input  wire logic                    rst_n,
    input  wire copad_pkg::roll_match_t  roll_match,
    input  wire logic                    neighbor_roll,
    output copad_pkg::match_vec_t        match,
    output copad_pkg::match_vec_t        match_upper,
    output copad_pkg::match_vec_t        match_lower,
    output logic                         any_match
);

    import copad_pkg::*;

    match_vec_t combined;    // same roll plus neighbours when enabled

    // -------------------------------------------------------------------
    // combine
    // -------------------------------------------------------------------

    always_comb begin
        combined = roll_match.same
                 | ({`COPAD_NUM_CLUSTERS{neighbor_roll}}
                    & (roll_match.upper | roll_match.lower));
    end

    // -------------------------------------------------------------------
    // output registers
    // -------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            match       <= '0;
            match_upper <= '0;
            match_lower <= '0;
            any_match   <= 1'b0;
        end else begin
            match       <= combined;
            match_upper <= roll_match.upper;    // raw flags whatever neighbor_roll says
            match_lower <= roll_match.lower;
            any_match   <= |combined;
        end
    end

    // summary flag must track the registered vector in every cycle
    any_match_is_or: assert property (
        @(posedge clock) disable iff (!rst_n) any_match == (|match)
    ) else $error("any_match %b disagrees with match %b", any_match, match);

endmodule

`default_nettype wire

// ==== copad_match_array.sv ====
// copad_match_array: pairwise A/B cluster comparison for same, upper and lower rolls
`default_nettype none

`include "copad_config.svh"

module copad_match_array (
    input  wire copad_pkg::chamber_clusters_t  gem_a,
    input  wire copad_pkg::chamber_clusters_t  gem_b,
    input  wire copad_pkg::match_cfg_t         cfg,
    output copad_pkg::roll_match_t             roll_match
);

    import copad_pkg::*;

    localparam int NUM    = `COPAD_NUM_CLUSTERS;
    localparam int ROLL_W = `COPAD_ROLL_BITS;
    localparam int LAST_W = `COPAD_PAD_BITS + 1;    // pad + cnt can pass 255

    pad_t [NUM-1:0] win_lo;    // window per A cluster
    pad_t [NUM-1:0] win_hi;

    // -------------------------------------------------------------------
    // one pad window per chamber-A cluster
    // -------------------------------------------------------------------

    for (genvar a = 0; a < NUM; a++) begin : g_window
        pad_window pad_window_inst (
            .cluster (gem_a[a]),
            .cfg     (cfg),
            .pad_lo  (win_lo[a]),
            .pad_hi  (win_hi[a])
        );
    end

    // -------------------------------------------------------------------
    // pair comparison, OR-ed over all B clusters
    // -------------------------------------------------------------------

    always_comb begin : pair_match
        logic [LAST_W-1:0] b_first;
        logic [LAST_W-1:0] b_last;
        logic [LAST_W-1:0] lo;
        logic [LAST_W-1:0] hi;
        logic              overlap;
        logic              hit;
        logic              a_top;
        logic              a_bottom;

        roll_match = '0;

        for (int a = 0; a < NUM; a++) begin
            lo       = LAST_W'(win_lo[a]);
            hi       = LAST_W'(win_hi[a]);
            a_bottom = (gem_a[a].roll == '0);    // no roll below roll 0
            a_top    = (gem_a[a].roll == '1);    // no roll above roll 7

            for (int b = 0; b < NUM; b++) begin
                b_first = LAST_W'(gem_b[b].pad);
                b_last  = LAST_W'(gem_b[b].pad) + LAST_W'(gem_b[b].cnt);

                // either end pad of B inside the window, limits included
                overlap = ((b_first >= lo) && (b_first <= hi))
                       || ((b_last >= lo) && (b_last <= hi));

                hit = gem_a[a].valid && gem_b[b].valid && overlap;

                if (hit && (gem_a[a].roll == gem_b[b].roll)) begin
                    roll_match.same[a] = 1'b1;
                end

                // B sits on the roll below A
                if (hit && !a_bottom
                        && (gem_a[a].roll == ROLL_W'(gem_b[b].roll + ROLL_W'(1)))) begin
                    roll_match.upper[a] = 1'b1;
                end

                // B sits on the roll above A
                if (hit && !a_top
                        && (ROLL_W'(gem_a[a].roll + ROLL_W'(1)) == gem_b[b].roll)) begin
                    roll_match.lower[a] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== pad_window.sv ====
// pad_window: clamped pad search window around one chamber-A cluster
`default_nettype none

`include "copad_config.svh"

module pad_window (
    input  wire copad_pkg::cluster_t    cluster,
    input  wire copad_pkg::match_cfg_t  cfg,
    output copad_pkg::pad_t             pad_lo,
    output copad_pkg::pad_t             pad_hi
);

    import copad_pkg::*;

    // two spare bits so pad + cnt + delta never wraps
    localparam int WIDE_W = `COPAD_PAD_BITS + 2;

    pad_t              delta;     // zero unless neighbour pads are enabled
    logic [WIDE_W-1:0] hi_sum;

    always_comb begin
        delta = cfg.neighbor_pad ? pad_t'(cfg.delta_pad) : '0;

        // lower edge, clamp at pad 0
        if (cluster.pad < delta) begin
            pad_lo = '0;
        end else begin
            pad_lo = cluster.pad - delta;
        end

        // upper edge is the last pad of the cluster plus delta
        hi_sum = WIDE_W'(cluster.pad) + WIDE_W'(cluster.cnt) + WIDE_W'(delta);
        if (hi_sum > WIDE_W'(`COPAD_MAX_PAD)) begin
            pad_hi = pad_t'(`COPAD_MAX_PAD);    // clamp at the last pad
        end else begin
            pad_hi = hi_sum[`COPAD_PAD_BITS-1:0];
        end

        // a legal pad always gives a non-empty window
        if (cluster.pad <= pad_t'(`COPAD_MAX_PAD)) begin
            assert (pad_lo <= pad_hi)
                else $error("pad window inverted: lo %0d hi %0d", pad_lo, pad_hi);
        end
    end

endmodule

`default_nettype wire

// ==== cluster_input_stage.sv ====
// cluster_input_stage: input register for both chambers and the match configuration
`default_nettype none

`include "copad_config.svh"

module cluster_input_stage (
    input  wire logic                          clock,
    input  wire logic                          rst_n,
    input  wire copad_pkg::chamber_clusters_t  gem_a,
    input  wire copad_pkg::chamber_clusters_t  gem_b,
    input  wire copad_pkg::match_cfg_t         cfg,
    output copad_pkg::chamber_clusters_t       gem_a_q,
    output copad_pkg::chamber_clusters_t       gem_b_q,
    output copad_pkg::match_cfg_t              cfg_q
);

    import copad_pkg::*;

    chamber_clusters_t                a_data_q;    // roll, pad and count fields
    chamber_clusters_t                b_data_q;
    logic [`COPAD_NUM_CLUSTERS-1:0]   a_valid_q;
    logic [`COPAD_NUM_CLUSTERS-1:0]   b_valid_q;

    // -------------------------------------------------------------------
    // registers
    // -------------------------------------------------------------------

    always_ff @(posedge clock) begin
        a_data_q <= gem_a;
        b_data_q <= gem_b;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            a_valid_q <= '0;
            b_valid_q <= '0;
            cfg_q     <= '0;
        end else begin
            for (int i = 0; i < `COPAD_NUM_CLUSTERS; i++) begin
                a_valid_q[i] <= gem_a[i].valid;
                b_valid_q[i] <= gem_b[i].valid;
            end
            cfg_q <= cfg;
        end
    end

    // valid flags come from the reset register, the rest from the data register
    always_comb begin
        gem_a_q = a_data_q;
        gem_b_q = b_data_q;
        for (int i = 0; i < `COPAD_NUM_CLUSTERS; i++) begin
            gem_a_q[i].valid = a_valid_q[i];
            gem_b_q[i].valid = b_valid_q[i];
        end
    end

    // nothing may match in the first crossing after reset
    no_valid_after_reset: assert property (
        @(posedge clock) !rst_n |=> (a_valid_q == '0) && (b_valid_q == '0)
    ) else $error("cluster valid set in the cycle after reset");

endmodule

`default_nettype wire

// ==== copad_pkg.sv ====
// copad_pkg: cluster, chamber, configuration and match vector types
`default_nettype none

`include "copad_config.svh"

package copad_pkg;

    // -------------------------------------------------------------------
    // cluster data
    // -------------------------------------------------------------------

    typedef logic [`COPAD_PAD_BITS-1:0] pad_t;    // one pad number

    typedef struct packed {
        logic                        valid;    // cluster present this crossing
        logic [`COPAD_ROLL_BITS-1:0] roll;     // eta partition
        pad_t                        pad;      // first pad of the cluster
        logic [`COPAD_CNT_BITS-1:0]  cnt;      // additional pads after the first
    } cluster_t;

    // index is the cluster number within the chamber
    typedef cluster_t [`COPAD_NUM_CLUSTERS-1:0] chamber_clusters_t;

    // -------------------------------------------------------------------
    // configuration and results
    // -------------------------------------------------------------------

    typedef struct packed {
        logic                         neighbor_roll;  // also accept rolls +/- 1
        logic                         neighbor_pad;   // widen window by delta_pad
        logic [`COPAD_DELTA_BITS-1:0] delta_pad;
    } match_cfg_t;

    // one bit per chamber-A cluster
    typedef logic [`COPAD_NUM_CLUSTERS-1:0] match_vec_t;

    typedef struct packed {
        match_vec_t same;     // B on the same roll
        match_vec_t upper;    // B one roll below A
        match_vec_t lower;    // B one roll above A
    } roll_match_t;

endpackage

`default_nettype wire

// ==== copad_config.svh ====
// size macros for the co-pad finder: cluster count, field widths, pad range
`ifndef COPAD_CONFIG_SVH
`define COPAD_CONFIG_SVH

// -------------------------------------------------------------------
// chamber geometry
// -------------------------------------------------------------------

`define COPAD_NUM_CLUSTERS 8    // clusters per chamber per crossing

// roll 0..7 and pad 0..191 on every roll
`define COPAD_ROLL_BITS    3
`define COPAD_PAD_BITS     8
`define COPAD_MAX_PAD      191

// a cluster covers pad .. pad + cnt
`define COPAD_CNT_BITS     3

// -------------------------------------------------------------------
// matching
// -------------------------------------------------------------------

`define COPAD_DELTA_BITS   4    // delta pad 0..15

`endif
